/* riscCore.f */
design/coreDefs.sv
design/instDecoder.sv
design/regFile.sv
design/execUnit.sv
design/dataMem.sv
design/singleCycleCore.sv
testbench/coreChecker.sv
testbench/coreTb.sv

/* testbench/coreTb.sv */
// Testbench top with clock, reset, random RV32I program, load and run control
// Comparison against the reference model happens in coreChecker
`timescale 1ns/1ps

module coreTb;
    import coreDefs::*;

    localparam int progLen     = 137;               // 16 clears, 120 random, 1 illegal
    localparam int seed        = 92;
    localparam int haltTimeout = 2000;              // Cycles

    logic                    clk;
    logic                    rst;
    logic                    run;
    logic                    loadEn;
    logic [imemAddrBits-1:0] loadAddr;
    instT                    loadData;
    logic                    halt;
    logic                    commitValid;
    xlenT                    commitPc;
    logic                    commitWrEn;
    regAddrT                 commitRd;
    xlenT                    commitData;
    int                      errorCount, commitCount, modelCount;
    instT                    prog [progLen];
    int                      cycles;
    logic                    timedOut;

    singleCycleCore i_singleCycleCore (
        .clk(clk), .rst(rst), .run(run), .loadEn(loadEn), .loadAddr(loadAddr),
        .loadData(loadData), .halt(halt), .commitValid(commitValid), .commitPc(commitPc),
        .commitWrEn(commitWrEn), .commitRd(commitRd), .commitData(commitData)
    );

    coreChecker u_checker (
        .clk(clk), .rst(rst), .run(run), .loadEn(loadEn), .loadAddr(loadAddr),
        .loadData(loadData), .halt(halt), .commitValid(commitValid), .commitPc(commitPc),
        .commitWrEn(commitWrEn), .commitRd(commitRd), .commitData(commitData),
        .errorCount(errorCount), .commitCount(commitCount), .modelCount(modelCount)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                     // 100 ns period
    end

    ////////////////////
    // Instruction encoders
    function automatic instT rType(input logic [6:0] f7, input regAddrT rs2, input regAddrT rs1,
                                   input logic [2:0] f3, input regAddrT rd, input opcodeT op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic instT iType(input logic [11:0] imm, input regAddrT rs1,
                                   input logic [2:0] f3, input regAddrT rd, input opcodeT op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic instT sType(input logic [11:0] imm, input regAddrT rs2,
                                   input regAddrT rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
    endfunction

    function automatic instT bType(input logic [12:0] imm, input regAddrT rs2,
                                   input regAddrT rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic instT uType(input logic [19:0] imm, input regAddrT rd, input opcodeT op);
        return {imm, rd, op};
    endfunction

    function automatic instT jType(input logic [20:0] imm, input regAddrT rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
    endfunction

    // Aligned data offset below 64
    function automatic int unsigned alignedOffset(input logic [1:0] size);
        int unsigned off;
        off = $urandom % 64;
        if (size == 2'd1) off = off & ~32'd1;
        else if (size == 2'd2) off = off & ~32'd3;
        return off;
    endfunction

    ////////////////////
    // Random program
    function automatic instT randomInstr(input int idx);
        int unsigned kind;
        int unsigned span;
        int unsigned jumpBytes;
        logic [2:0]  f3;
        regAddrT     rd, rs1, rs2;
        logic        alt;
        logic [11:0] imm12;
        kind      = $urandom % 9;
        rd        = regAddrT'($urandom % 8);        // Small set including x0
        rs1       = regAddrT'($urandom % 8);
        rs2       = regAddrT'($urandom % 8);
        f3        = 3'($urandom);
        alt       = 1'($urandom);
        span      = progLen - 1 - idx;              // Words left up to the illegal word
        if (span > 8) span = 8;
        jumpBytes = 4 * (1 + $urandom % span);      // Forward only
        case (kind)
            0: begin
                alt = alt && (f3 == 3'd0 || f3 == 3'd5);
                return rType(alt ? funct7Alt : 7'd0, rs2, rs1, f3, rd, opCompute);
            end
            1: begin
                imm12 = 12'($urandom);
                if (f3 == 3'd1) imm12 = {7'd0, imm12[4:0]};
                else if (f3 == 3'd5) imm12 = {alt ? funct7Alt : 7'd0, imm12[4:0]};
                return iType(imm12, rs1, f3, rd, opImmediate);
            end
            2: return uType(20'($urandom), rd, opLui);
            3: return uType(20'($urandom), rd, opAuipc);
            4: begin
                f3 = 3'($urandom % 5);
                if (f3 >= 3'd3) f3 = f3 + 3'd1;     // LB LH LW LBU LHU
                return iType(12'(alignedOffset(f3[1:0])), 5'd0, f3, rd, opLoad);
            end
            5: begin
                f3 = 3'($urandom % 3);
                return sType(12'(alignedOffset(f3[1:0])), rs2, 5'd0, f3);
            end
            6: begin
                f3 = 3'($urandom % 6);
                if (f3 >= 3'd2) f3 = f3 + 3'd2;     // Skip reserved codes
                return bType(13'(jumpBytes), rs2, rs1, f3);
            end
            7: return jType(21'(jumpBytes), rd);
            default: return iType(12'(4 * idx + jumpBytes), 5'd0, 3'd0, rd, opJalr);
        endcase
    endfunction

    task automatic buildProgram();
        for (int i = 0; i < 16; i++) prog[i] = sType(12'(4 * i), 5'd0, 5'd0, 3'd2);
        for (int i = 16; i < progLen - 1; i++) prog[i] = randomInstr(i);
        prog[progLen - 1] = '0;                     // Illegal word ends the run
    endtask

    task automatic loadProgram();
        for (int i = 0; i < progLen; i++) begin
            loadEn   = 1'b1;
            loadAddr = imemAddrBits'(i);
            loadData = prog[i];
            @(negedge clk);
        end
        loadEn = 1'b0;
    endtask

    ////////////////////
    // Run control
    initial begin
        void'($urandom(seed));
        rst      = 1'b1;
        run      = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        timedOut = 1'b0;
        buildProgram();
        repeat (4) @(negedge clk);                  // Four reset cycles
        rst = 1'b0;
        loadProgram();
        run    = 1'b1;
        cycles = 0;
        while (!halt && cycles < haltTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!halt) begin
            timedOut = 1'b1;
            $display("Core never halted within %0d cycles", haltTimeout);
        end
        repeat (5) @(negedge clk);                  // Halt must hold
        if (commitCount != modelCount) begin
            $display("Commit count does not match the model's instruction count");
        end
        $display("Errors: %0d, commits: %0d, model instructions: %0d",
                 errorCount, commitCount, modelCount);
        if (timedOut || errorCount != 0 || commitCount != modelCount) begin
            $display("Some tests failed");
        end else begin
            $display("All tests passed");
        end
        $finish;
    end

endmodule

/* testbench/coreChecker.sv */
// Reference model of the supported RV32I subset
// Mirrors the load port, steps with run and compares every commit
`timescale 1ns/1ps

module coreChecker (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              run,
    input  logic                              loadEn,
    input  logic [coreDefs::imemAddrBits-1:0] loadAddr,
    input  coreDefs::instT                    loadData,
    input  logic                              halt,
    input  logic                              commitValid,
    input  coreDefs::xlenT                    commitPc,
    input  logic                              commitWrEn,
    input  coreDefs::regAddrT                 commitRd,
    input  coreDefs::xlenT                    commitData,
    output int                                errorCount,
    output int                                commitCount,
    output int                                modelCount
);
    import coreDefs::*;

    instT       imemCopy [imemDepth];
    xlenT       regs [32];
    logic [7:0] dmemBytes [dmemDepth * 4];          // Byte-wide model memory
    xlenT       pcModel;
    logic       halted;                             // Model reached the illegal word

    task automatic reportMismatch(input string field, input xlenT expected, input xlenT actual);
        $display("FAILED at %0t: %s expected %h, got %h", $time, field, expected, actual);
        errorCount++;
    endtask

    // Integer ops per funct3, alt picks SUB (R-type only) and SRA
    function automatic xlenT aluRef(input logic [2:0] f3, input logic alt, input logic isReg,
                                    input xlenT x, input xlenT y);
        case (f3)
            3'd0:    return (isReg && alt) ? x - y : x + y;
            3'd1:    return x << y[4:0];
            3'd2:    return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'd3:    return (x < y) ? 32'd1 : 32'd0;
            3'd4:    return x ^ y;
            3'd5:    return alt ? xlenT'($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'd6:    return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic xlenT loadRef(input int unsigned ba, input logic [2:0] f3);
        logic [7:0]  b0;
        logic [15:0] h;
        b0 = dmemBytes[ba];
        h  = {dmemBytes[ba + 1], dmemBytes[ba]};
        case (f3)
            3'd0:    return {{24{b0[7]}}, b0};      // LB
            3'd1:    return {{16{h[15]}}, h};       // LH
            3'd4:    return {24'd0, b0};            // LBU
            3'd5:    return {16'd0, h};             // LHU
            default: return {dmemBytes[ba + 3], dmemBytes[ba + 2], h};
        endcase
    endfunction

    task automatic storeRef(input int unsigned ba, input logic [2:0] f3, input xlenT v);
        dmemBytes[ba] = v[7:0];
        if (f3 != 3'd0) dmemBytes[ba + 1] = v[15:8];
        if (f3 == 3'd2) begin
            dmemBytes[ba + 2] = v[23:16];
            dmemBytes[ba + 3] = v[31:24];
        end
    endtask

    ////////////////////
    // One model step, compared against the commit port
    task automatic executeOne();
        instT        ins;
        logic [2:0]  f3;
        regAddrT     rd;
        xlenT        a, b, immI, immS, immB, immU, immJ, result, nextPc;
        logic        wr, legal, take;
        int unsigned ba;
        ins    = imemCopy[pcModel[imemAddrBits+1:2]];
        f3     = ins[14:12];
        rd     = ins[11:7];
        a      = regs[ins[19:15]];
        b      = regs[ins[24:20]];
        immI   = {{20{ins[31]}}, ins[31:20]};
        immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        immU   = {ins[31:12], 12'd0};
        immJ   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        nextPc = pcModel + 32'd4;
        result = '0;
        wr     = 1'b1;
        legal  = 1'b1;
        take   = 1'b0;
        case (ins[6:0])
            opCompute:   result = aluRef(f3, ins[30], 1'b1, a, b);
            opImmediate: result = aluRef(f3, ins[30], 1'b0, a, immI);
            opLui:       result = immU;
            opAuipc:     result = pcModel + immU;
            opLoad:      result = loadRef((a + immI) % (dmemDepth * 4), f3);
            opStore: begin
                wr = 1'b0;
                ba = (a + immS) % (dmemDepth * 4);
            end
            opBranch: begin
                wr = 1'b0;
                case (f3)
                    3'd0:    take = (a == b);
                    3'd1:    take = (a != b);
                    3'd4:    take = ($signed(a) < $signed(b));
                    3'd5:    take = ($signed(a) >= $signed(b));
                    3'd6:    take = (a < b);
                    3'd7:    take = (a >= b);
                    default: take = 1'b0;
                endcase
                if (take) nextPc = pcModel + immB;
            end
            opJal: begin
                result = pcModel + 32'd4;
                nextPc = pcModel + immJ;
            end
            opJalr: begin
                result = pcModel + 32'd4;
                nextPc = (a + immI) & ~32'd1;       // Target bit 0 cleared
            end
            default: legal = 1'b0;
        endcase
        if (rd == '0) wr = 1'b0;                    // x0 never written
        if (!legal) begin
            halted = 1'b1;
            if (!halt) reportMismatch("halt", 32'd1, 32'd0);
            if (commitValid) reportMismatch("commitValid", 32'd0, 32'd1);
        end else begin
            if (!commitValid) begin
                reportMismatch("commitValid", 32'd1, 32'd0);
            end else begin
                if (commitPc !== pcModel) reportMismatch("commitPc", pcModel, commitPc);
                if (commitWrEn !== wr) reportMismatch("commitWrEn", 32'(wr), 32'(commitWrEn));
                if (wr && commitRd !== rd) reportMismatch("commitRd", 32'(rd), 32'(commitRd));
                if (wr && commitData !== result) reportMismatch("commitData", result, commitData);
            end
            if (ins[6:0] == opStore) storeRef(ba, f3, b);
            if (wr) regs[rd] = result;
            pcModel = nextPc;
            modelCount++;
        end
    endtask

    // Instruction copy from the load port
    always @(posedge clk) begin
        if (loadEn && !run) imemCopy[loadAddr] = loadData;
    end

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) regs[i] = '0;
            pcModel     = '0;
            halted      = 1'b0;
            errorCount  = 0;
            commitCount = 0;
            modelCount  = 0;
        end else if (run) begin
            if (commitValid) commitCount++;
            if (halted) begin
                if (!halt) reportMismatch("halt", 32'd1, 32'd0);      // Must stay halted
                if (commitValid) reportMismatch("commitValid", 32'd0, 32'd1);
            end else begin
                executeOne();
            end
        end
    end

endmodule

/* design/singleCycleCore.sv */
// Single-cycle RV32I core top level
// PC register, instruction memory with load port, halt, writeback, commit port
`timescale 1ns/1ps

module singleCycleCore (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              run,
    input  logic                              loadEn,
    input  logic [coreDefs::imemAddrBits-1:0] loadAddr,
    input  coreDefs::instT                    loadData,
    output logic                              halt,
    output logic                              commitValid,
    output coreDefs::xlenT                    commitPc,
    output logic                              commitWrEn,
    output coreDefs::regAddrT                 commitRd,
    output coreDefs::xlenT                    commitData
);
    import coreDefs::*;

    xlenT    pc;
    xlenT    pcPlus4;
    instT    imem [imemDepth];
    instT    instr;
    logic    retire;                            // Instruction completes this cycle
    regAddrT rs1, rs2, rd;
    xlenT    imm;
    aluOpT   aluOp;
    logic    useImm, usePcA, isBranch, isJal, isJalr;
    logic [2:0] branchCond;
    logic    regWrite, memRead, memWrite, loadUnsigned, illegal;
    memSizeT memSize;
    wbSelT   wbSel;
    xlenT    rdata1, rdata2;
    xlenT    aluResult, nextPc, memData, wbData;
    logic    rfWrEn;

    ////////////////////
    // Fetch
    always_ff @(posedge clk) begin
        if (loadEn && !run) imem[loadAddr] <= loadData;   // Load port, idle core only
    end

    assign instr   = imem[pc[imemAddrBits+1:2]];
    assign pcPlus4 = pc + 32'd4;

    assign halt   = illegal;
    assign retire = run && !halt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
        end else if (retire) begin
            pc <= nextPc;
        end
    end

    ////////////////////
    // Datapath
    instDecoder u_instDecoder (
        .instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
        .aluOp(aluOp), .useImm(useImm), .usePcA(usePcA),
        .isBranch(isBranch), .branchCond(branchCond), .isJal(isJal), .isJalr(isJalr),
        .regWrite(regWrite), .memRead(memRead), .memWrite(memWrite),
        .memSize(memSize), .loadUnsigned(loadUnsigned), .wbSel(wbSel), .illegal(illegal)
    );

    assign rfWrEn = retire && regWrite && (rd != '0);   // x0 never reported

    regFile u_regFile (
        .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd),
        .wrEn(rfWrEn), .wrData(wbData), .rdata1(rdata1), .rdata2(rdata2)
    );

    execUnit u_execUnit (
        .pc(pc), .rs1Val(rdata1), .rs2Val(rdata2), .imm(imm),
        .aluOp(aluOp), .useImm(useImm), .usePcA(usePcA),
        .isBranch(isBranch), .branchCond(branchCond), .isJal(isJal), .isJalr(isJalr),
        .aluResult(aluResult), .nextPc(nextPc)
    );

    dataMem u_dataMem (
        .clk(clk), .memWrite(retire && memWrite), .memRead(memRead),
        .memSize(memSize), .loadUnsigned(loadUnsigned),
        .addr(aluResult), .wrData(rdata2), .rdData(memData)
    );

    // Writeback select
    always_comb begin
        case (wbSel)
            wbMem:   wbData = memData;
            wbPc4:   wbData = pcPlus4;          // JAL/JALR link
            default: wbData = aluResult;
        endcase
    end

    // Commit port
    assign commitValid = retire;
    assign commitPc    = pc;
    assign commitWrEn  = rfWrEn;
    assign commitRd    = rd;
    assign commitData  = wbData;

endmodule

/* design/dataMem.sv */
// Byte-addressed data memory with sized stores
// Combinational loads with sign or zero extension
`timescale 1ns/1ps

module dataMem (
    input  logic              clk,
    input  logic              memWrite,
    input  logic              memRead,
    input  coreDefs::memSizeT memSize,
    input  logic              loadUnsigned,
    input  coreDefs::xlenT    addr,
    input  coreDefs::xlenT    wrData,
    output coreDefs::xlenT    rdData
);
    import coreDefs::*;

    xlenT                    mem [dmemDepth];
    logic [dmemAddrBits-1:0] wordIdx;           // Upper bits ignored, wraps
    logic [1:0]              byteOff;
    logic [3:0]              byteEn;
    xlenT                    laneData;          // Store data copied onto lanes
    xlenT                    word;
    logic [7:0]              byteVal;
    logic [15:0]             halfVal;
    xlenT                    loadVal;

    assign wordIdx = addr[dmemAddrBits+1:2];
    assign byteOff = addr[1:0];

    ////////////////////
    // Store path
    always_comb begin
        case (memSize)
            sizeByte: begin
                byteEn   = 4'b0001 << byteOff;
                laneData = {4{wrData[7:0]}};
            end
            sizeHalf: begin
                byteEn   = byteOff[1] ? 4'b1100 : 4'b0011;
                laneData = {2{wrData[15:0]}};
            end
            default: begin
                byteEn   = 4'b1111;
                laneData = wrData;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (memWrite) begin
            for (int b = 0; b < 4; b++) begin
                if (byteEn[b]) mem[wordIdx][b*8 +: 8] <= laneData[b*8 +: 8];
            end
        end
    end

    ////////////////////
    // Load path
    assign word    = mem[wordIdx];
    assign byteVal = word[byteOff*8 +: 8];
    assign halfVal = byteOff[1] ? word[31:16] : word[15:0];

    always_comb begin
        case (memSize)
            sizeByte: loadVal = loadUnsigned ? {24'b0, byteVal}
                                             : {{24{byteVal[7]}}, byteVal};
            sizeHalf: loadVal = loadUnsigned ? {16'b0, halfVal}
                                             : {{16{halfVal[15]}}, halfVal};
            default:  loadVal = word;
        endcase
    end

    assign rdData = memRead ? loadVal : '0;     // Quiet when not loading

endmodule

/* design/execUnit.sv */
// Execute stage: operand select, ALU, branch compare
// Next-PC choice for sequential flow, branches, JAL and JALR
`timescale 1ns/1ps

module execUnit (
    input  coreDefs::xlenT  pc,
    input  coreDefs::xlenT  rs1Val,
    input  coreDefs::xlenT  rs2Val,
    input  coreDefs::xlenT  imm,
    input  coreDefs::aluOpT aluOp,
    input  logic            useImm,
    input  logic            usePcA,
    input  logic            isBranch,
    input  logic [2:0]      branchCond,
    input  logic            isJal,
    input  logic            isJalr,
    output coreDefs::xlenT  aluResult,
    output coreDefs::xlenT  nextPc
);
    import coreDefs::*;

    xlenT       opA;
    xlenT       opB;
    logic [4:0] shamt;
    logic       eq;                             // rs1 == rs2
    logic       ltSigned;
    logic       ltUnsigned;
    logic       taken;
    xlenT       pcPlus4;
    xlenT       pcTarget;

    assign opA   = usePcA ? pc : rs1Val;        // AUIPC uses PC
    assign opB   = useImm ? imm : rs2Val;
    assign shamt = opB[4:0];

    ////////////////////
    // ALU
    always_comb begin
        case (aluOp)
            aluAdd:   aluResult = opA + opB;
            aluSub:   aluResult = opA - opB;
            aluSll:   aluResult = opA << shamt;
            aluSlt:   aluResult = {31'b0, $signed(opA) < $signed(opB)};
            aluSltu:  aluResult = {31'b0, opA < opB};
            aluXor:   aluResult = opA ^ opB;
            aluSrl:   aluResult = opA >> shamt;
            aluSra:   aluResult = xlenT'($signed(opA) >>> shamt);
            aluOr:    aluResult = opA | opB;
            aluAnd:   aluResult = opA & opB;
            default:  aluResult = opB;          // aluPassB for LUI
        endcase
    end

    ////////////////////
    // Branch compare, always on the register values
    assign eq         = (rs1Val == rs2Val);
    assign ltSigned   = ($signed(rs1Val) < $signed(rs2Val));
    assign ltUnsigned = (rs1Val < rs2Val);

    always_comb begin
        case (branchCond)
            f3Beq:   taken = eq;
            f3Bne:   taken = !eq;
            f3Blt:   taken = ltSigned;
            f3Bge:   taken = !ltSigned;
            f3Bltu:  taken = ltUnsigned;
            f3Bgeu:  taken = !ltUnsigned;
            default: taken = 1'b0;              // Reserved codes fall through
        endcase
    end

    // Next PC
    assign pcPlus4  = pc + 32'd4;
    assign pcTarget = pc + imm;                 // Branch and JAL target

    always_comb begin
        if (isJalr) begin
            nextPc = {aluResult[31:1], 1'b0};   // rs1+imm, bit 0 cleared
        end else if (isJal || (isBranch && taken)) begin
            nextPc = pcTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

endmodule

/* design/regFile.sv */
// 32-entry integer register file, x0 reads as zero
// Two asynchronous read ports, one write port on the rising edge
`timescale 1ns/1ps

module regFile (
    input  logic              clk,
    input  logic              rst,
    input  coreDefs::regAddrT rs1,
    input  coreDefs::regAddrT rs2,
    input  coreDefs::regAddrT rd,
    input  logic              wrEn,
    input  coreDefs::xlenT    wrData,
    output coreDefs::xlenT    rdata1,
    output coreDefs::xlenT    rdata2
);
    import coreDefs::*;

    xlenT regs [1:31];                          // No storage behind x0

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (rd != '0)) begin
            regs[rd] <= wrData;                 // x0 writes dropped
        end
    end

    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* design/instDecoder.sv */
// Instruction decoder: field split, immediate build, control levels
// Flags any opcode outside the supported RV32I subset
`timescale 1ns/1ps

module instDecoder (
    input  coreDefs::instT    instr,
    output coreDefs::regAddrT rs1,
    output coreDefs::regAddrT rs2,
    output coreDefs::regAddrT rd,
    output coreDefs::xlenT    imm,
    output coreDefs::aluOpT   aluOp,
    output logic              useImm,
    output logic              usePcA,
    output logic              isBranch,
    output logic [2:0]        branchCond,
    output logic              isJal,
    output logic              isJalr,
    output logic              regWrite,
    output logic              memRead,
    output logic              memWrite,
    output coreDefs::memSizeT memSize,
    output logic              loadUnsigned,
    output coreDefs::wbSelT   wbSel,
    output logic              illegal
);
    import coreDefs::*;

    opcodeT     opcode;
    logic [2:0] funct3;
    logic       altSel;                         // funct7 picks SUB/SRA
    xlenT       iImm, sImm, bImm, uImm, jImm;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign altSel = (instr[31:25] == funct7Alt);

    assign rs1        = instr[19:15];
    assign rs2        = instr[24:20];
    assign rd         = instr[11:7];
    assign branchCond = funct3;                 // Interpreted by execUnit

    assign iImm = {{20{instr[31]}}, instr[31:20]};
    assign sImm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign bImm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign uImm = {instr[31:12], 12'b0};
    assign jImm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    // Sizes shared by loads and stores
    assign loadUnsigned = (funct3 == f3Lbu) || (funct3 == f3Lhu);
    always_comb begin
        case (funct3)
            f3Lb, f3Lbu: memSize = sizeByte;
            f3Lh, f3Lhu: memSize = sizeHalf;
            default:     memSize = sizeWord;    // f3Lw
        endcase
    end

    // ALU op from funct3, SUB only exists in R-type
    function automatic aluOpT aluFromFunct(input logic [2:0] f3, input logic alt,
                                           input logic isReg);
        case (f3)
            f3AddSub: return (alt && isReg) ? aluSub : aluAdd;
            f3Sll:    return aluSll;
            f3Slt:    return aluSlt;
            f3Sltu:   return aluSltu;
            f3Xor:    return aluXor;
            f3SrlSra: return alt ? aluSra : aluSrl;
            f3Or:     return aluOr;
            default:  return aluAnd;            // f3And
        endcase
    endfunction

    ////////////////////
    // Control levels per opcode class
    always_comb begin
        imm      = '0;
        aluOp    = aluAdd;                      // Address and AUIPC sum by default
        useImm   = 1'b0;
        usePcA   = 1'b0;
        isBranch = 1'b0;
        isJal    = 1'b0;
        isJalr   = 1'b0;
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        wbSel    = wbAlu;
        illegal  = 1'b0;
        case (opcode)
            opCompute: begin
                regWrite = 1'b1;
                aluOp    = aluFromFunct(funct3, altSel, 1'b1);
            end
            opImmediate: begin
                regWrite = 1'b1;
                useImm   = 1'b1;
                imm      = iImm;
                aluOp    = aluFromFunct(funct3, altSel, 1'b0);
            end
            opLoad: begin
                regWrite = 1'b1;
                memRead  = 1'b1;
                useImm   = 1'b1;
                imm      = iImm;
                wbSel    = wbMem;
            end
            opStore: begin
                memWrite = 1'b1;
                useImm   = 1'b1;
                imm      = sImm;
            end
            opBranch: begin
                isBranch = 1'b1;
                imm      = bImm;
            end
            opJal: begin
                isJal    = 1'b1;
                regWrite = 1'b1;
                imm      = jImm;
                wbSel    = wbPc4;               // Link address
            end
            opJalr: begin
                isJalr   = 1'b1;
                regWrite = 1'b1;
                useImm   = 1'b1;                // ALU forms rs1+imm
                imm      = iImm;
                wbSel    = wbPc4;
            end
            opLui: begin
                regWrite = 1'b1;
                useImm   = 1'b1;
                imm      = uImm;
                aluOp    = aluPassB;
            end
            opAuipc: begin
                regWrite = 1'b1;
                useImm   = 1'b1;
                usePcA   = 1'b1;
                imm      = uImm;
            end
            default: illegal = 1'b1;            // Halts the core
        endcase
    end

endmodule

/* design/coreDefs.sv */
// Shared types and constants for the RV32I single-cycle core
// Opcodes, funct codes, ALU/writeback/size enums and memory depths
package coreDefs;

    ////////////////////
    // Basic vector types
    typedef logic [31:0] xlenT;                    // Data and address word
    typedef logic [4:0]  regAddrT;                 // Register index
    typedef logic [31:0] instT;                    // Instruction word
    typedef logic [6:0]  opcodeT;                  // Major opcode

    ////////////////////
    // Opcode classes
    localparam opcodeT opCompute   = 7'b0110011;   // R-type ALU
    localparam opcodeT opImmediate = 7'b0010011;   // I-type ALU
    localparam opcodeT opBranch    = 7'b1100011;
    localparam opcodeT opLoad      = 7'b0000011;
    localparam opcodeT opStore     = 7'b0100011;
    localparam opcodeT opJal       = 7'b1101111;
    localparam opcodeT opJalr      = 7'b1100111;
    localparam opcodeT opLui       = 7'b0110111;
    localparam opcodeT opAuipc     = 7'b0010111;

    // ALU funct3
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // Branch funct3
    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    // Load/store size funct3, stores share the signed codes
    localparam logic [2:0] f3Lb  = 3'b000;
    localparam logic [2:0] f3Lh  = 3'b001;
    localparam logic [2:0] f3Lw  = 3'b010;
    localparam logic [2:0] f3Lbu = 3'b100;
    localparam logic [2:0] f3Lhu = 3'b101;

    localparam logic [6:0] funct7Alt = 7'b0100000; // SUB and SRA select

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
        aluSrl, aluSra, aluOr, aluAnd, aluPassB
    } aluOpT;

    typedef enum logic [1:0] {wbAlu, wbMem, wbPc4} wbSelT;

    typedef enum logic [1:0] {sizeByte = 2'b00, sizeHalf = 2'b01, sizeWord = 2'b10} memSizeT;

    ////////////////////
    // Memory geometry, in 32-bit words
    localparam int imemDepth    = 256;
    localparam int dmemDepth    = 256;
    localparam int imemAddrBits = $clog2(imemDepth);
    localparam int dmemAddrBits = $clog2(dmemDepth);

endpackage
